// File: source/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN = 32;

    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_CSR       = 7'b1110011
    } opcode_e;

    // Arithmetic funct3
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    // Loads and stores
    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;
    localparam logic [2:0] FNC_SB  = 3'b000;
    localparam logic [2:0] FNC_SH  = 3'b001;
    localparam logic [2:0] FNC_SW  = 3'b010;

    // Branches, jumps and CSR
    localparam logic [2:0] FNC_BEQ   = 3'b000;
    localparam logic [2:0] FNC_BNE   = 3'b001;
    localparam logic [2:0] FNC_BLT   = 3'b100;
    localparam logic [2:0] FNC_BGE   = 3'b101;
    localparam logic [2:0] FNC_BLTU  = 3'b110;
    localparam logic [2:0] FNC_BGEU  = 3'b111;
    localparam logic [2:0] FNC_JALR  = 3'b000;
    localparam logic [2:0] FNC_CSRRW = 3'b001;

    localparam logic [6:0] FNC7_BASE = 7'b0000000;
    localparam logic [6:0] FNC7_ALT  = 7'b0100000;

    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    function automatic opcode_e opcode_of(input logic [31:0] inst);
        return opcode_e'(inst[6:0]);
    endfunction

    function automatic logic [4:0] rd_of(input logic [31:0] inst);
        return inst[RD_LSB +: 5];
    endfunction

    function automatic logic [4:0] rs1_of(input logic [31:0] inst);
        return inst[RS1_LSB +: 5];
    endfunction

    function automatic logic [4:0] rs2_of(input logic [31:0] inst);
        return inst[RS2_LSB +: 5];
    endfunction

    function automatic logic [2:0] funct3_of(input logic [31:0] inst);
        return inst[FUNCT3_LSB +: 3];
    endfunction

    function automatic logic [6:0] funct7_of(input logic [31:0] inst);
        return inst[FUNCT7_LSB +: 7];
    endfunction

endpackage

`default_nettype wire

// File: source/decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_sel_e;

    typedef enum logic [1:0] {
        TGT_BR,
        TGT_JAL,
        TGT_JALR,
        TGT_NONE
    } tgt_sel_e;

    // Source of rs1 for the JALR target
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // ADDI x0, x0, 0
    localparam logic [31:0] BUBBLE_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// File: source/decode_ifs.sv
`timescale 1ns/10ps
`default_nettype none

interface stage_view_if (
    input logic clk,
    input logic rst
);
    logic [31:0] ex_inst;
    logic [31:0] mem_inst;
    logic [31:0] wb_inst;
    logic [4:0]  ex_rd;
    logic [4:0]  mem_rd;
    logic [4:0]  wb_rd;
    logic        ex_has_rd;
    logic        mem_has_rd;
    logic        wb_has_rd;
    logic [31:0] wb_result;

    modport tracker (
        output ex_inst, mem_inst, wb_inst,
        output ex_rd, mem_rd, wb_rd,
        output ex_has_rd, mem_has_rd, wb_has_rd,
        output wb_result
    );

    modport ctrl (
        input clk, rst,
        input ex_inst, mem_inst, wb_inst,
        input ex_rd, mem_rd, wb_rd,
        input ex_has_rd, mem_has_rd, wb_has_rd
    );

    modport rf (
        input wb_rd, wb_has_rd, wb_result
    );
endinterface

interface target_ctrl_if (
    input logic clk,
    input logic rst
);
    logic                      target_en;
    decode_ctrl_pkg::tgt_sel_e tgt_sel;
    decode_ctrl_pkg::fwd_sel_e fwd_sel;
    logic [31:0]               imm;

    modport ctrl (output target_en, tgt_sel, fwd_sel);
    modport imm_drv (output imm);
    modport gen (input clk, rst, target_en, tgt_sel, fwd_sel, imm);
endinterface

`default_nettype wire

// File: source/id_control.sv
`timescale 1ns/10ps
`default_nettype none

module id_control (
    input  logic [31:0]               inst,
    stage_view_if.ctrl                sv,
    target_ctrl_if.ctrl               tc,
    output logic                      stall,
    output decode_ctrl_pkg::imm_sel_e imm_sel
);
    riscv_isa_pkg::opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;
    logic       is_store;
    logic       ex_load;
    logic       load_use_rs1;
    logic       load_use_rs2;

    assign opcode = riscv_isa_pkg::opcode_of(inst);
    assign funct3 = riscv_isa_pkg::funct3_of(inst);
    assign funct7 = riscv_isa_pkg::funct7_of(inst);
    assign rs1    = riscv_isa_pkg::rs1_of(inst);
    assign rs2    = riscv_isa_pkg::rs2_of(inst);

    assign has_rs1 = opcode != riscv_isa_pkg::OPC_LUI && opcode != riscv_isa_pkg::OPC_AUIPC
        && opcode != riscv_isa_pkg::OPC_JAL
        && (opcode != riscv_isa_pkg::OPC_CSR || funct3 == riscv_isa_pkg::FNC_CSRRW)
        && rs1 != 5'd0;
    assign has_rs2 = (opcode == riscv_isa_pkg::OPC_ARI_RTYPE || opcode == riscv_isa_pkg::OPC_STORE
        || opcode == riscv_isa_pkg::OPC_BRANCH) && rs2 != 5'd0;
    assign is_store = opcode == riscv_isa_pkg::OPC_STORE;

    // ex_has_rd is already false for x0 and bubbles
    assign ex_load      = riscv_isa_pkg::opcode_of(sv.ex_inst) == riscv_isa_pkg::OPC_LOAD;
    assign load_use_rs1 = ex_load && sv.ex_has_rd && rs1 == sv.ex_rd;
    assign load_use_rs2 = ex_load && sv.ex_has_rd && rs2 == sv.ex_rd;

    // Store data is picked up later in MEM so only the address counts
    assign stall = (has_rs1 && load_use_rs1) || (has_rs2 && !is_store && load_use_rs2);

    always_comb begin
        tc.fwd_sel = decode_ctrl_pkg::FWD_NONE;
        if (sv.ex_has_rd && rs1 == sv.ex_rd) begin
            tc.fwd_sel = decode_ctrl_pkg::FWD_EX;
        end else if (sv.mem_has_rd && rs1 == sv.mem_rd) begin
            tc.fwd_sel = decode_ctrl_pkg::FWD_MEM;
        end else if (sv.wb_has_rd && rs1 == sv.wb_rd) begin
            tc.fwd_sel = decode_ctrl_pkg::FWD_WB;
        end
    end

    always_comb begin
        imm_sel      = decode_ctrl_pkg::IMM_NONE;
        tc.tgt_sel   = decode_ctrl_pkg::TGT_NONE;
        tc.target_en = 1'b0;
        case (opcode)
            riscv_isa_pkg::OPC_ARI_ITYPE: begin
                case (funct3)
                    riscv_isa_pkg::FNC_SLL: begin
                        if (funct7 == riscv_isa_pkg::FNC7_BASE) begin
                            imm_sel = decode_ctrl_pkg::IMM_I;
                        end
                    end
                    riscv_isa_pkg::FNC_SRL_SRA: begin
                        if (funct7 == riscv_isa_pkg::FNC7_BASE
                            || funct7 == riscv_isa_pkg::FNC7_ALT) begin
                            imm_sel = decode_ctrl_pkg::IMM_I;
                        end
                    end
                    default: imm_sel = decode_ctrl_pkg::IMM_I;
                endcase
            end
            riscv_isa_pkg::OPC_LOAD: begin
                case (funct3)
                    riscv_isa_pkg::FNC_LB, riscv_isa_pkg::FNC_LH, riscv_isa_pkg::FNC_LW,
                    riscv_isa_pkg::FNC_LBU, riscv_isa_pkg::FNC_LHU: begin
                        imm_sel = decode_ctrl_pkg::IMM_I;
                    end
                    default: ;
                endcase
            end
            riscv_isa_pkg::OPC_STORE: begin
                case (funct3)
                    riscv_isa_pkg::FNC_SB, riscv_isa_pkg::FNC_SH, riscv_isa_pkg::FNC_SW: begin
                        imm_sel = decode_ctrl_pkg::IMM_S;
                    end
                    default: ;
                endcase
            end
            riscv_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    riscv_isa_pkg::FNC_BEQ, riscv_isa_pkg::FNC_BNE, riscv_isa_pkg::FNC_BLT,
                    riscv_isa_pkg::FNC_BGE, riscv_isa_pkg::FNC_BLTU,
                    riscv_isa_pkg::FNC_BGEU: begin
                        imm_sel      = decode_ctrl_pkg::IMM_B;
                        tc.tgt_sel   = decode_ctrl_pkg::TGT_BR;
                        tc.target_en = 1'b1;
                    end
                    default: ;
                endcase
            end
            riscv_isa_pkg::OPC_JAL: begin
                imm_sel      = decode_ctrl_pkg::IMM_J;
                tc.tgt_sel   = decode_ctrl_pkg::TGT_JAL;
                tc.target_en = 1'b1;
            end
            riscv_isa_pkg::OPC_JALR: begin
                if (funct3 == riscv_isa_pkg::FNC_JALR) begin
                    imm_sel      = decode_ctrl_pkg::IMM_I;
                    tc.tgt_sel   = decode_ctrl_pkg::TGT_JALR;
                    // Load result is not ready yet
                    tc.target_en = !load_use_rs1;
                end
            end
            riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC: begin
                imm_sel = decode_ctrl_pkg::IMM_U;
            end
            default: ;
        endcase
    end

    // The stalling load moves on to MEM while EX gets a bubble
    a_stall_moves_load: assert property (@(posedge sv.clk) disable iff (sv.rst)
        stall |=> (riscv_isa_pkg::opcode_of(sv.mem_inst) == riscv_isa_pkg::OPC_LOAD
            && sv.ex_inst == decode_ctrl_pkg::BUBBLE_INST))
        else $error("stall did not hold a load back behind a bubble");

endmodule

`default_nettype wire

// File: source/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input logic [31:0]               inst,
    input decode_ctrl_pkg::imm_sel_e imm_sel,
    target_ctrl_if.imm_drv           tc
);
    always_comb begin
        case (imm_sel)
            decode_ctrl_pkg::IMM_I: begin
                tc.imm = {{20{inst[31]}}, inst[31:20]};
            end
            decode_ctrl_pkg::IMM_S: begin
                tc.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            // B and J are halfword offsets
            decode_ctrl_pkg::IMM_B: begin
                tc.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            decode_ctrl_pkg::IMM_U: begin
                tc.imm = {inst[31:12], 12'b0};
            end
            decode_ctrl_pkg::IMM_J: begin
                tc.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                tc.imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/target_gen.sv
`timescale 1ns/10ps
`default_nettype none

module target_gen (
    target_ctrl_if.gen  tc,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] ex_result,
    input  logic [31:0] mem_result,
    input  logic [31:0] wb_result,
    output logic [31:0] target_addr
);
    logic [31:0] rs1_value;
    logic [31:0] base;
    logic [31:0] sum;

    always_comb begin
        case (tc.fwd_sel)
            decode_ctrl_pkg::FWD_EX:  rs1_value = ex_result;
            decode_ctrl_pkg::FWD_MEM: rs1_value = mem_result;
            decode_ctrl_pkg::FWD_WB:  rs1_value = wb_result;
            default:                  rs1_value = rs1_data;
        endcase
    end

    assign base = (tc.tgt_sel == decode_ctrl_pkg::TGT_JALR) ? rs1_value : pc;
    assign sum  = base + tc.imm;

    // JALR drops the low bit
    assign target_addr = (tc.tgt_sel == decode_ctrl_pkg::TGT_JALR) ? {sum[31:1], 1'b0} : sum;

    // Register file must hold a written value when no forward applies
    a_jalr_rs1_known: assert property (@(posedge tc.clk) disable iff (tc.rst)
        (tc.target_en && tc.tgt_sel == decode_ctrl_pkg::TGT_JALR
            && tc.fwd_sel == decode_ctrl_pkg::FWD_NONE) |-> !$isunknown(rs1_data))
        else $error("JALR target built from unknown rs1 data");

endmodule

`default_nettype wire

// File: source/stage_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module stage_tracker (
    input logic        clk,
    input logic        rst,
    input logic        id_valid,
    input logic        stall,
    input logic [31:0] id_inst,
    input logic [31:0] wb_result,
    stage_view_if.tracker sv
);
    logic [31:0] ex_q;
    logic [31:0] mem_q;
    logic [31:0] wb_q;

    function automatic logic writes_rd(input logic [31:0] inst);
        riscv_isa_pkg::opcode_e opc;
        opc = riscv_isa_pkg::opcode_of(inst);
        return opc != riscv_isa_pkg::OPC_STORE && opc != riscv_isa_pkg::OPC_BRANCH
            && opc != riscv_isa_pkg::OPC_CSR && riscv_isa_pkg::rd_of(inst) != 5'd0;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q  <= decode_ctrl_pkg::BUBBLE_INST;
            mem_q <= decode_ctrl_pkg::BUBBLE_INST;
            wb_q  <= decode_ctrl_pkg::BUBBLE_INST;
        end else begin
            // Bubble into EX on a stall or an empty slot
            if (id_valid && !stall) begin
                ex_q <= id_inst;
            end else begin
                ex_q <= decode_ctrl_pkg::BUBBLE_INST;
            end
            mem_q <= ex_q;
            wb_q  <= mem_q;
        end
    end

    assign sv.ex_inst  = ex_q;
    assign sv.mem_inst = mem_q;
    assign sv.wb_inst  = wb_q;

    assign sv.ex_rd  = riscv_isa_pkg::rd_of(ex_q);
    assign sv.mem_rd = riscv_isa_pkg::rd_of(mem_q);
    assign sv.wb_rd  = riscv_isa_pkg::rd_of(wb_q);

    assign sv.ex_has_rd  = writes_rd(ex_q);
    assign sv.mem_has_rd = writes_rd(mem_q);
    assign sv.wb_has_rd  = writes_rd(wb_q);

    assign sv.wb_result = wb_result;

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    output logic [31:0] rs1_data,
    stage_view_if.rf    sv
);
    logic [riscv_isa_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (sv.wb_has_rd) begin
            regs[sv.wb_rd] <= sv.wb_result;
        end
    end

    // x0 stays zero because WB never flags a write to it
    assign rs1_data = regs[rs1_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1_addr == 5'd0) |-> (rs1_data == 32'd0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        id_valid,
    input  logic [31:0] id_inst,
    input  logic [31:0] id_pc,
    input  logic [31:0] ex_result,
    input  logic [31:0] mem_result,
    input  logic [31:0] wb_result,
    output logic        stall,
    output logic [31:0] imm,
    output logic        target_valid,
    output logic [31:0] target_addr,
    output logic [31:0] ex_inst
);
    decode_ctrl_pkg::imm_sel_e imm_sel;
    logic [31:0] rs1_data;

    stage_view_if  sv (.clk(clk), .rst(rst));
    target_ctrl_if tc (.clk(clk), .rst(rst));

    id_control u_id_control (
        .inst    (id_inst),
        .sv      (sv),
        .tc      (tc),
        .stall   (stall),
        .imm_sel (imm_sel)
    );

    imm_gen u_imm_gen (
        .inst    (id_inst),
        .imm_sel (imm_sel),
        .tc      (tc)
    );

    target_gen u_target_gen (
        .tc          (tc),
        .pc          (id_pc),
        .rs1_data    (rs1_data),
        .ex_result   (ex_result),
        .mem_result  (mem_result),
        .wb_result   (wb_result),
        .target_addr (target_addr)
    );

    stage_tracker u_stage_tracker (
        .clk       (clk),
        .rst       (rst),
        .id_valid  (id_valid),
        .stall     (stall),
        .id_inst   (id_inst),
        .wb_result (wb_result),
        .sv        (sv)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (riscv_isa_pkg::rs1_of(id_inst)),
        .rs1_data (rs1_data),
        .sv       (sv)
    );

    assign imm          = tc.imm;
    assign ex_inst      = sv.ex_inst;
    assign target_valid = tc.target_en && id_valid && !stall;

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);
    localparam int HALF_PERIOD_NS = 4;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: bench/decode_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;

    localparam string STIM_FILE     = "bench/decode_stimulus.txt";
    localparam int    RESET_CYCLES  = 4;
    localparam int    RESET_TIMEOUT = 20;
    localparam int    MAX_LINES     = 1000;

    logic        clk;
    logic        rst;
    logic        id_valid;
    logic [31:0] id_inst;
    logic [31:0] id_pc;
    logic [31:0] ex_result;
    logic [31:0] mem_result;
    logic [31:0] wb_result;
    logic        stall;
    logic [31:0] imm;
    logic        target_valid;
    logic [31:0] target_addr;
    logic [31:0] ex_inst;

    tb_clock u_clock (.clk(clk));

    decode_stage dut (
        .clk          (clk),
        .rst          (rst),
        .id_valid     (id_valid),
        .id_inst      (id_inst),
        .id_pc        (id_pc),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .stall        (stall),
        .imm          (imm),
        .target_valid (target_valid),
        .target_addr  (target_addr),
        .ex_inst      (ex_inst)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "%s", reason);
    endtask

    // Reset release after four rising edges
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    initial begin
        int fd;
        int fields;
        int wait_cnt;
        int line_cnt;
        int vec_cnt;
        string line;
        logic [31:0] f_valid;
        logic [31:0] f_inst;
        logic [31:0] f_pc;
        logic [31:0] f_ex;
        logic [31:0] f_mem;
        logic [31:0] f_wb;
        logic [31:0] x_stall;
        logic [31:0] x_imm;
        logic [31:0] x_tv;
        logic [31:0] x_addr;
        logic [31:0] x_ex_inst;

        rst        = 1'b1;
        id_valid   = 1'b0;
        id_inst    = 32'h0000_0013;
        id_pc      = 32'd0;
        ex_result  = 32'd0;
        mem_result = 32'd0;
        wb_result  = 32'd0;
        vec_cnt    = 0;
        line_cnt   = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end

        wait_cnt = 0;
        while (rst) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end

        while (!$feof(fd)) begin
            line_cnt++;
            if (line_cnt > MAX_LINES) begin
                abort_run("stimulus file has more lines than expected");
            end
            if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                 f_valid, f_inst, f_pc, f_ex, f_mem, f_wb,
                                 x_stall, x_imm, x_tv, x_addr, x_ex_inst);
                if (fields != 11) begin
                    abort_run($sformatf("malformed stimulus line %0d", line_cnt));
                end
                #1;
                id_valid   = f_valid[0];
                id_inst    = f_inst;
                id_pc      = f_pc;
                ex_result  = f_ex;
                mem_result = f_mem;
                wb_result  = f_wb;
                // Outputs settle well before the next edge
                #5;
                check_value("stall", x_stall, {31'd0, stall});
                check_value("imm", x_imm, imm);
                check_value("target_valid", x_tv, {31'd0, target_valid});
                if (x_tv[0]) begin
                    check_value("target_addr", x_addr, target_addr);
                end
                check_value("ex_inst", x_ex_inst, ex_inst);
                vec_cnt++;
                @(posedge clk);
            end
        end
        $fclose(fd);

        if (vec_cnt == 0) begin
            abort_run("no vectors found in the stimulus file");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/decode_stimulus.txt
# valid inst pc ex_result mem_result wb_result exp_stall exp_imm exp_target_valid exp_target_addr exp_ex_inst
# all hex; exp_target_addr is compared only when exp_target_valid is 1
0 00000013 00000000 00000000 00000000 00000000 0 00000000 0 00000000 00000013
1 FFB00293 00000100 00000000 00000000 00000000 0 FFFFFFFB 0 00000000 00000013
1 FE20AA23 00000104 00000000 00000000 00000000 0 FFFFFFF4 0 00000000 FFB00293
1 FE4198E3 00000200 00000000 00000000 00000000 0 FFFFFFF0 1 000001F0 FE20AA23
1 12345437 00000204 00000000 00000000 00002000 0 12345000 0 00000000 FE4198E3
1 805FF0EF 00001000 00000000 00000000 00000000 0 FFFFF804 1 00000804 12345437
1 006284B3 00001004 00000000 00000000 00000000 0 00000000 0 00000000 805FF0EF
1 01048067 00001008 00003001 AAAA0000 55550000 0 00000010 1 00003010 006284B3
1 FFC48067 0000100C 11110000 00004000 00000700 0 FFFFFFFC 1 00003FFC 01048067
1 00848067 00001010 11110000 22220000 00005001 0 00000008 1 00005008 FFC48067
1 02028067 00001014 11110000 22220000 33330000 0 00000020 1 00002020 00848067
1 00108067 00001018 11110000 22220000 33330000 0 00000001 1 00000700 02028067
1 00100513 0000101C 00000000 00000000 00000000 0 00000001 0 00000000 00108067
1 00250513 00001020 00000000 00000000 00000000 0 00000002 0 00000000 00100513
1 00050067 00001024 00006000 00007000 00008000 0 00000000 1 00006000 00250513
1 00050067 00001028 00006100 00007100 00008100 0 00000000 1 00007100 00050067
1 00812583 0000102C 00000000 00000000 00000000 0 00000008 0 00000000 00050067
1 00B18633 00001030 00000000 00000000 00000000 1 00000000 0 00000000 00812583
1 00B18633 00001030 00000000 00000000 00000000 0 00000000 0 00000000 00000013
1 00002683 00001034 00000000 00000000 00000000 0 00000000 0 00000000 00B18633
1 00D0A223 00001038 00000000 00000000 00000000 0 00000004 0 00000000 00002683
1 00002703 0000103C 00000000 00000000 00000000 0 00000000 0 00000000 00D0A223
1 00272023 00001040 00000000 00000000 00000000 1 00000000 0 00000000 00002703
1 00272023 00001040 00000000 00000000 00000000 0 00000000 0 00000000 00000013
1 00002783 00001044 00000000 00000000 00000000 0 00000000 0 00000000 00272023
1 040780E7 00001048 00000000 00000000 00000000 1 00000040 0 00000000 00002783
1 040780E7 00001048 00001111 00009000 00002222 0 00000040 1 00009040 00000013
0 805FF0EF 0000104C 00000000 00000000 00000000 0 FFFFF804 0 00000000 040780E7
0 00000013 00000000 00000000 00000000 00000000 0 00000000 0 00000000 00000013

// File: flist.f
source/riscv_isa_pkg.sv
source/decode_ctrl_pkg.sv
source/decode_ifs.sv
source/id_control.sv
source/imm_gen.sv
source/target_gen.sv
source/stage_tracker.sv
source/reg_file.sv
source/decode_stage.sv
bench/tb_clock.sv
bench/decode_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps \
    --top-module decode_stage_tb \
    -Mdir obj_dir -o decode_stage_sim \
    -f flist.f

./obj_dir/decode_stage_sim
